//--- hdl/net_slice_array.sv
`timescale 1ns/10ps

`include "net_slice_settings.svh"

module net_slice_array #(
  parameter int STAGES = `NET_SLICE_STAGES
) (
  input  logic                       aclk,
  input  logic                       rst,
  // ARP lookup request, user to network
  input  net_slice_pkg::arp_lup_req_t arp_req_in_data,
  input  logic                       arp_req_in_valid,
  output logic                       arp_req_in_ready,
  output net_slice_pkg::arp_lup_req_t arp_req_out_data,
  output logic                       arp_req_out_valid,
  input  logic                       arp_req_out_ready,
  // ARP lookup reply, network to user
  input  net_slice_pkg::arp_lup_rsp_t arp_rsp_in_data,
  input  logic                       arp_rsp_in_valid,
  output logic                       arp_rsp_in_ready,
  output net_slice_pkg::arp_lup_rsp_t arp_rsp_out_data,
  output logic                       arp_rsp_out_valid,
  input  logic                       arp_rsp_out_ready,
  // Set IP address, user to network
  input  net_slice_pkg::ip_addr_t     set_ip_in_data,
  input  logic                       set_ip_in_valid,
  output logic                       set_ip_in_ready,
  output net_slice_pkg::ip_addr_t     set_ip_out_data,
  output logic                       set_ip_out_valid,
  input  logic                       set_ip_out_ready,
  // Set MAC address, user to network
  input  net_slice_pkg::mac_addr_t    set_mac_in_data,
  input  logic                       set_mac_in_valid,
  output logic                       set_mac_in_ready,
  output net_slice_pkg::mac_addr_t    set_mac_out_data,
  output logic                       set_mac_out_valid,
  input  logic                       set_mac_out_ready,
  // Statistics, network to user
  input  net_slice_pkg::net_stat_t    stat_in,
  output net_slice_pkg::net_stat_t    stat_out
);

  import net_slice_pkg::*;

  // Chain taps, index 0 is the input and index STAGES the output
  arp_lup_req_t [STAGES:0] arp_req_d;
  logic         [STAGES:0] arp_req_v;
  logic         [STAGES:0] arp_req_r;
  arp_lup_rsp_t [STAGES:0] arp_rsp_d;
  logic         [STAGES:0] arp_rsp_v;
  logic         [STAGES:0] arp_rsp_r;
  ip_addr_t     [STAGES:0] set_ip_d;
  logic         [STAGES:0] set_ip_v;
  logic         [STAGES:0] set_ip_r;
  mac_addr_t    [STAGES:0] set_mac_d;
  logic         [STAGES:0] set_mac_v;
  logic         [STAGES:0] set_mac_r;

  // Statistics shift register, no handshake
  net_stat_t [STAGES-1:0] stat_q;

  // Chain ends
  assign arp_req_d[0]      = arp_req_in_data;
  assign arp_req_v[0]      = arp_req_in_valid;
  assign arp_req_in_ready  = arp_req_r[0];
  assign arp_req_out_data  = arp_req_d[STAGES];
  assign arp_req_out_valid = arp_req_v[STAGES];
  assign arp_req_r[STAGES] = arp_req_out_ready;

  assign arp_rsp_d[0]      = arp_rsp_in_data;
  assign arp_rsp_v[0]      = arp_rsp_in_valid;
  assign arp_rsp_in_ready  = arp_rsp_r[0];
  assign arp_rsp_out_data  = arp_rsp_d[STAGES];
  assign arp_rsp_out_valid = arp_rsp_v[STAGES];
  assign arp_rsp_r[STAGES] = arp_rsp_out_ready;

  assign set_ip_d[0]       = set_ip_in_data;
  assign set_ip_v[0]       = set_ip_in_valid;
  assign set_ip_in_ready   = set_ip_r[0];
  assign set_ip_out_data   = set_ip_d[STAGES];
  assign set_ip_out_valid  = set_ip_v[STAGES];
  assign set_ip_r[STAGES]  = set_ip_out_ready;

  assign set_mac_d[0]      = set_mac_in_data;
  assign set_mac_v[0]      = set_mac_in_valid;
  assign set_mac_in_ready  = set_mac_r[0];
  assign set_mac_out_data  = set_mac_d[STAGES];
  assign set_mac_out_valid = set_mac_v[STAGES];
  assign set_mac_r[STAGES] = set_mac_out_ready;

  // One slice per channel per stage
  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    reg_slice #(.WIDTH($bits(arp_lup_req_t))) arp_req_slice (
      .aclk(aclk), .rst(rst),
      .in_data(arp_req_d[i]), .in_valid(arp_req_v[i]), .in_ready(arp_req_r[i]),
      .out_data(arp_req_d[i+1]), .out_valid(arp_req_v[i+1]), .out_ready(arp_req_r[i+1])
    );
    reg_slice #(.WIDTH($bits(arp_lup_rsp_t))) arp_rsp_slice (
      .aclk(aclk), .rst(rst),
      .in_data(arp_rsp_d[i]), .in_valid(arp_rsp_v[i]), .in_ready(arp_rsp_r[i]),
      .out_data(arp_rsp_d[i+1]), .out_valid(arp_rsp_v[i+1]), .out_ready(arp_rsp_r[i+1])
    );
    reg_slice #(.WIDTH($bits(ip_addr_t))) set_ip_slice (
      .aclk(aclk), .rst(rst),
      .in_data(set_ip_d[i]), .in_valid(set_ip_v[i]), .in_ready(set_ip_r[i]),
      .out_data(set_ip_d[i+1]), .out_valid(set_ip_v[i+1]), .out_ready(set_ip_r[i+1])
    );
    reg_slice #(.WIDTH($bits(mac_addr_t))) set_mac_slice (
      .aclk(aclk), .rst(rst),
      .in_data(set_mac_d[i]), .in_valid(set_mac_v[i]), .in_ready(set_mac_r[i]),
      .out_data(set_mac_d[i+1]), .out_valid(set_mac_v[i+1]), .out_ready(set_mac_r[i+1])
    );
  end

  // Statistics word advances every cycle
  always_ff @(posedge aclk) begin
    if (rst) begin
      stat_q <= '0;
    end else begin
      stat_q[0] <= stat_in;
      for (int k = 1; k < STAGES; k++) begin
        stat_q[k] <= stat_q[k-1];
      end
    end
  end

  assign stat_out = stat_q[STAGES-1];

endmodule

//--- hdl/net_slice_pkg.sv
`include "net_slice_settings.svh"

package net_slice_pkg;

  // IPv4 address
  typedef logic [31:0] ip_addr_t;

  // Ethernet MAC address
  typedef logic [47:0] mac_addr_t;

  // ARP lookup request from the user region
  typedef struct packed {
    // Address to be resolved
    ip_addr_t ip_addr;
  } arp_lup_req_t;

  // ARP lookup reply from the network stack
  typedef struct packed {
    // Set when the table held an entry
    logic      hit;
    // Resolved hardware address
    mac_addr_t mac_addr;
    // Echo of the address that was asked about
    ip_addr_t  ip_addr;
  } arp_lup_rsp_t;

  // Network statistics word
  // One free running counter per event kind
  typedef struct packed {
    // Received packets
    logic [`NET_STAT_WIDTH-1:0] rx_pkts;
    // Transmitted packets
    logic [`NET_STAT_WIDTH-1:0] tx_pkts;
    // ARP packets in
    logic [`NET_STAT_WIDTH-1:0] arp_rx;
    // ARP packets out
    logic [`NET_STAT_WIDTH-1:0] arp_tx;
  } net_stat_t;

endpackage

//--- hdl/net_slice_top.sv
`timescale 1ns/10ps

`include "net_slice_settings.svh"

module net_slice_top (
  input  logic                       aclk,
  input  logic                       rst,
  // User side
  input  net_slice_pkg::arp_lup_req_t arp_req_user_data,
  input  logic                       arp_req_user_valid,
  output logic                       arp_req_user_ready,
  input  net_slice_pkg::ip_addr_t     set_ip_user_data,
  input  logic                       set_ip_user_valid,
  output logic                       set_ip_user_ready,
  input  net_slice_pkg::mac_addr_t    set_mac_user_data,
  input  logic                       set_mac_user_valid,
  output logic                       set_mac_user_ready,
  output net_slice_pkg::arp_lup_rsp_t arp_rsp_user_data,
  output logic                       arp_rsp_user_valid,
  input  logic                       arp_rsp_user_ready,
  // Network side
  output net_slice_pkg::arp_lup_req_t arp_req_net_data,
  output logic                       arp_req_net_valid,
  input  logic                       arp_req_net_ready,
  output net_slice_pkg::ip_addr_t     set_ip_net_data,
  output logic                       set_ip_net_valid,
  input  logic                       set_ip_net_ready,
  output net_slice_pkg::mac_addr_t    set_mac_net_data,
  output logic                       set_mac_net_valid,
  input  logic                       set_mac_net_ready,
  input  net_slice_pkg::arp_lup_rsp_t arp_rsp_net_data,
  input  logic                       arp_rsp_net_valid,
  output logic                       arp_rsp_net_ready,
  // Network event strobes
  input  logic                       rx_pkt,
  input  logic                       tx_pkt,
  input  logic                       arp_rx,
  input  logic                       arp_tx,
  // Statistics delivered to the user region
  output net_slice_pkg::net_stat_t    stat_user
);

  import net_slice_pkg::*;

  // Collector output before the pipeline
  net_stat_t stat_net;

  // Counters live on the network side
  net_stat_collect net_stat_collect_i (
    .aclk(aclk),
    .rst(rst),
    .rx_pkt(rx_pkt),
    .tx_pkt(tx_pkt),
    .arp_rx(arp_rx),
    .arp_tx(arp_tx),
    .stat(stat_net)
  );

  // Requests and settings flow user to network, replies and stats back
  net_slice_array #(.STAGES(`NET_SLICE_STAGES)) net_slice_array_i (
    .aclk(aclk),
    .rst(rst),
    .arp_req_in_data(arp_req_user_data),
    .arp_req_in_valid(arp_req_user_valid),
    .arp_req_in_ready(arp_req_user_ready),
    .arp_req_out_data(arp_req_net_data),
    .arp_req_out_valid(arp_req_net_valid),
    .arp_req_out_ready(arp_req_net_ready),
    .arp_rsp_in_data(arp_rsp_net_data),
    .arp_rsp_in_valid(arp_rsp_net_valid),
    .arp_rsp_in_ready(arp_rsp_net_ready),
    .arp_rsp_out_data(arp_rsp_user_data),
    .arp_rsp_out_valid(arp_rsp_user_valid),
    .arp_rsp_out_ready(arp_rsp_user_ready),
    .set_ip_in_data(set_ip_user_data),
    .set_ip_in_valid(set_ip_user_valid),
    .set_ip_in_ready(set_ip_user_ready),
    .set_ip_out_data(set_ip_net_data),
    .set_ip_out_valid(set_ip_net_valid),
    .set_ip_out_ready(set_ip_net_ready),
    .set_mac_in_data(set_mac_user_data),
    .set_mac_in_valid(set_mac_user_valid),
    .set_mac_in_ready(set_mac_user_ready),
    .set_mac_out_data(set_mac_net_data),
    .set_mac_out_valid(set_mac_net_valid),
    .set_mac_out_ready(set_mac_net_ready),
    .stat_in(stat_net),
    .stat_out(stat_user)
  );

endmodule

//--- hdl/net_stat_collect.sv
`timescale 1ns/10ps

`include "net_slice_settings.svh"

module net_stat_collect (
  input  logic                    aclk,
  input  logic                    rst,
  // One cycle event strobes from the network stack
  input  logic                    rx_pkt,
  input  logic                    tx_pkt,
  input  logic                    arp_rx,
  input  logic                    arp_tx,
  // Current counter values
  output net_slice_pkg::net_stat_t stat
);

  // Strobes widened to counter width
  logic [`NET_STAT_WIDTH-1:0] rx_pkt_inc;
  logic [`NET_STAT_WIDTH-1:0] tx_pkt_inc;
  logic [`NET_STAT_WIDTH-1:0] arp_rx_inc;
  logic [`NET_STAT_WIDTH-1:0] arp_tx_inc;

  assign rx_pkt_inc = `NET_STAT_WIDTH'(rx_pkt);
  assign tx_pkt_inc = `NET_STAT_WIDTH'(tx_pkt);
  assign arp_rx_inc = `NET_STAT_WIDTH'(arp_rx);
  assign arp_tx_inc = `NET_STAT_WIDTH'(arp_tx);

  // Each counter has its own adder
  // so coinciding strobes all count
  always_ff @(posedge aclk) begin
    if (rst) begin
      stat <= '0;
    end else begin
      // Plain wrap on overflow
      stat.rx_pkts <= stat.rx_pkts + rx_pkt_inc;
      stat.tx_pkts <= stat.tx_pkts + tx_pkt_inc;
      // ARP traffic counted apart from the packet totals
      stat.arp_rx  <= stat.arp_rx + arp_rx_inc;
      stat.arp_tx  <= stat.arp_tx + arp_tx_inc;
    end
  end

endmodule

//--- hdl/reg_slice.sv
`timescale 1ns/10ps

module reg_slice #(
  parameter int WIDTH = 32
) (
  input  logic             aclk,
  input  logic             rst,
  // Upstream side
  input  logic [WIDTH-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  // Downstream side
  output logic [WIDTH-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  // Skid register catches the item that arrives during a stall
  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;

  // Main register may take a new item this cycle
  logic main_load;
  logic in_fire;

  assign main_load = out_ready | ~out_valid;
  assign in_fire   = in_valid & in_ready;

  // Control state
  always_ff @(posedge aclk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      // Ready comes up one cycle after reset
      in_ready   <= 1'b0;
    end else begin
      if (main_load) begin
        // Skid drains first to keep the order
        out_valid  <= skid_valid | in_fire;
        skid_valid <= 1'b0;
        in_ready   <= 1'b1;
      end else if (in_fire) begin
        // Stalled with an item arriving
        skid_valid <= 1'b1;
        in_ready   <= 1'b0;
      end
    end
  end

  // Payload path
  always_ff @(posedge aclk) begin
    if (main_load) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!main_load && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- include/net_slice_settings.svh
`ifndef NET_SLICE_SETTINGS_SVH
`define NET_SLICE_SETTINGS_SVH

// Register stages on every channel
// between the user region and the network stack
`define NET_SLICE_STAGES 2

// Width of one statistics counter
// Counters wrap at this width
`define NET_STAT_WIDTH 32

`endif

//--- net_slice.f
+incdir+include
hdl/net_slice_pkg.sv
hdl/reg_slice.sv
hdl/net_stat_collect.sv
hdl/net_slice_array.sv
hdl/net_slice_top.sv
tests/tb_net_slice.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_net_slice -o tb_net_slice \
  -f net_slice.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$build_log"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_net_slice > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "Test failed" "$sim_log"; then
  exit 1
fi
exit 0

//--- tests/tb_net_slice.sv
`timescale 1ns/10ps

`include "net_slice_settings.svh"

module tb_net_slice;

  import net_slice_pkg::*;

  localparam int stages         = `NET_SLICE_STAGES;
  localparam int timeout_cycles = 2000;
  localparam int req_count      = 20;
  localparam int rsp_count      = 30;
  localparam int strobe_cycles  = 200;
  localparam logic [`NET_STAT_WIDTH-1:0] stat_one = 1;

  logic aclk;
  logic rst;

  // User side
  arp_lup_req_t arp_req_user_data;
  logic         arp_req_user_valid;
  logic         arp_req_user_ready;
  ip_addr_t     set_ip_user_data;
  logic         set_ip_user_valid;
  logic         set_ip_user_ready;
  mac_addr_t    set_mac_user_data;
  logic         set_mac_user_valid;
  logic         set_mac_user_ready;
  arp_lup_rsp_t arp_rsp_user_data;
  logic         arp_rsp_user_valid;
  logic         arp_rsp_user_ready;
  // Network side
  arp_lup_req_t arp_req_net_data;
  logic         arp_req_net_valid;
  logic         arp_req_net_ready;
  ip_addr_t     set_ip_net_data;
  logic         set_ip_net_valid;
  logic         set_ip_net_ready;
  mac_addr_t    set_mac_net_data;
  logic         set_mac_net_valid;
  logic         set_mac_net_ready;
  arp_lup_rsp_t arp_rsp_net_data;
  logic         arp_rsp_net_valid;
  logic         arp_rsp_net_ready;
  logic         rx_pkt;
  logic         tx_pkt;
  logic         arp_rx;
  logic         arp_tx;
  net_stat_t    stat_user;

  integer seed;
  int     mismatch_count;
  int     timeout_count;
  int     cycle;
  string  test_name;
  bit     rsp_sent;

  // Scoreboard, pushed at input transfers
  arp_lup_req_t req_q[$];
  int           req_t_q[$];
  arp_lup_rsp_t rsp_q[$];
  ip_addr_t     ip_q[$];
  mac_addr_t    mac_q[$];

  // Heads popped by the monitor
  arp_lup_req_t exp_req;
  int           req_t_in;
  arp_lup_rsp_t exp_rsp;
  ip_addr_t     exp_ip;
  mac_addr_t    exp_mac;

  // Stimulus made ahead of forked senders
  arp_lup_req_t req_items[req_count];
  arp_lup_rsp_t rsp_items[rsp_count];
  ip_addr_t     ip_items[3];
  mac_addr_t    mac_items[4];
  net_stat_t    stat_exp;

  net_slice_top net_slice_top_i (.*);

  always #5 aclk = ~aclk;

  // Monitor, samples transfers at the rising edge
  always @(posedge aclk) begin
    cycle = cycle + 1;
    if (!rst) begin
      if (arp_req_user_valid && arp_req_user_ready) begin
        req_q.push_back(arp_req_user_data);
        req_t_q.push_back(cycle);
      end
      if (arp_rsp_net_valid && arp_rsp_net_ready) rsp_q.push_back(arp_rsp_net_data);
      if (set_ip_user_valid && set_ip_user_ready) ip_q.push_back(set_ip_user_data);
      if (set_mac_user_valid && set_mac_user_ready) mac_q.push_back(set_mac_user_data);

      if (arp_req_net_valid && arp_req_net_ready) begin
        assert (req_q.size() != 0) else begin
          $display("%s: arp request came out with none outstanding", test_name);
          mismatch_count++;
        end
        if (req_q.size() != 0) begin
          exp_req  = req_q.pop_front();
          req_t_in = req_t_q.pop_front();
          assert (arp_req_net_data == exp_req) else begin
            $display("FAILED %s arp_req expected %h actual %h",
                     test_name, exp_req, arp_req_net_data);
            mismatch_count++;
          end
          // Network ready is never dropped, so every request sees the bare latency
          assert (cycle - req_t_in == stages) else begin
            $display("FAILED %s arp_req latency expected %0d actual %0d",
                     test_name, stages, cycle - req_t_in);
            mismatch_count++;
          end
        end
      end

      if (arp_rsp_user_valid && arp_rsp_user_ready) begin
        assert (rsp_q.size() != 0) else begin
          $display("%s: arp reply came out with none outstanding", test_name);
          mismatch_count++;
        end
        if (rsp_q.size() != 0) begin
          exp_rsp = rsp_q.pop_front();
          assert (arp_rsp_user_data == exp_rsp) else begin
            $display("FAILED %s arp_rsp expected %h actual %h",
                     test_name, exp_rsp, arp_rsp_user_data);
            mismatch_count++;
          end
        end
      end

      if (set_ip_net_valid && set_ip_net_ready) begin
        assert (ip_q.size() != 0) else begin
          $display("%s: set IP item came out with none outstanding", test_name);
          mismatch_count++;
        end
        if (ip_q.size() != 0) begin
          exp_ip = ip_q.pop_front();
          assert (set_ip_net_data == exp_ip) else begin
            $display("FAILED %s set_ip expected %h actual %h",
                     test_name, exp_ip, set_ip_net_data);
            mismatch_count++;
          end
        end
      end

      if (set_mac_net_valid && set_mac_net_ready) begin
        assert (mac_q.size() != 0) else begin
          $display("%s: set MAC item came out with none outstanding", test_name);
          mismatch_count++;
        end
        if (mac_q.size() != 0) begin
          exp_mac = mac_q.pop_front();
          assert (set_mac_net_data == exp_mac) else begin
            $display("FAILED %s set_mac expected %h actual %h",
                     test_name, exp_mac, set_mac_net_data);
            mismatch_count++;
          end
        end
      end
    end
  end

  function automatic logic [31:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic mac_addr_t rand_mac();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_word();
    lo = rand_word();
    return {hi[15:0], lo};
  endfunction

  // True while any tracked channel still holds items
  function automatic bit busy(input bit include_ip);
    return req_q.size() != 0 || rsp_q.size() != 0 || mac_q.size() != 0 ||
           (include_ip && ip_q.size() != 0);
  endfunction

  // Senders start and end 1 ns after an edge; ready is read while stable
  task automatic send_req(input arp_lup_req_t d);
    int waited;
    arp_req_user_data  = d;
    arp_req_user_valid = 1'b1;
    waited = 0;
    while (!arp_req_user_ready && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (!arp_req_user_ready) begin
      $display("%s: arp request input never became ready", test_name);
      timeout_count++;
    end
    @(posedge aclk);
    #1;
    arp_req_user_valid = 1'b0;
  endtask

  task automatic send_rsp(input arp_lup_rsp_t d);
    int waited;
    arp_rsp_net_data  = d;
    arp_rsp_net_valid = 1'b1;
    waited = 0;
    while (!arp_rsp_net_ready && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (!arp_rsp_net_ready) begin
      $display("%s: arp reply input never became ready", test_name);
      timeout_count++;
    end
    @(posedge aclk);
    #1;
    arp_rsp_net_valid = 1'b0;
  endtask

  task automatic send_ip(input ip_addr_t d);
    int waited;
    set_ip_user_data  = d;
    set_ip_user_valid = 1'b1;
    waited = 0;
    while (!set_ip_user_ready && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (!set_ip_user_ready) begin
      $display("%s: set IP input never became ready", test_name);
      timeout_count++;
    end
    @(posedge aclk);
    #1;
    set_ip_user_valid = 1'b0;
  endtask

  task automatic send_mac(input mac_addr_t d);
    int waited;
    set_mac_user_data  = d;
    set_mac_user_valid = 1'b1;
    waited = 0;
    while (!set_mac_user_ready && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (!set_mac_user_ready) begin
      $display("%s: set MAC input never became ready", test_name);
      timeout_count++;
    end
    @(posedge aclk);
    #1;
    set_mac_user_valid = 1'b0;
  endtask

  task automatic wait_drain(input bit include_ip);
    int waited;
    waited = 0;
    while (busy(include_ip) && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (busy(include_ip)) begin
      $display("%s: channels did not drain in time", test_name);
      timeout_count++;
    end
  endtask

  task automatic check_counter(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act == exp) else begin
      $display("FAILED %s %s expected %0d actual %0d", test_name, name, exp, act);
      mismatch_count++;
    end
  endtask

  initial begin
    int waited;
    seed           = 69628;
    mismatch_count = 0;
    timeout_count  = 0;
    cycle          = 0;
    rsp_sent       = 1'b0;
    test_name      = "reset";
    aclk = 1'b0;
    rst  = 1'b1;
    arp_req_user_data  = '0;
    arp_req_user_valid = 1'b0;
    set_ip_user_data   = '0;
    set_ip_user_valid  = 1'b0;
    set_mac_user_data  = '0;
    set_mac_user_valid = 1'b0;
    arp_rsp_user_ready = 1'b1;
    arp_req_net_ready  = 1'b1;
    set_ip_net_ready   = 1'b1;
    set_mac_net_ready  = 1'b1;
    arp_rsp_net_data   = '0;
    arp_rsp_net_valid  = 1'b0;
    rx_pkt = 1'b0;
    tx_pkt = 1'b0;
    arp_rx = 1'b0;
    arp_tx = 1'b0;
    stat_exp = '0;

    repeat (16) @(posedge aclk);
    #1;
    rst = 1'b0;

    // Outputs quiet straight out of reset
    assert ({arp_req_net_valid, set_ip_net_valid, set_mac_net_valid,
             arp_rsp_user_valid} == 4'b0) else begin
      $display("FAILED %s valids expected 0 actual %b", test_name,
               {arp_req_net_valid, set_ip_net_valid, set_mac_net_valid, arp_rsp_user_valid});
      mismatch_count++;
    end
    assert (stat_user == '0) else begin
      $display("FAILED %s stat_user expected 0 actual %h", test_name, stat_user);
      mismatch_count++;
    end
    waited = 0;
    while (!(arp_req_user_ready && set_ip_user_ready && set_mac_user_ready &&
             arp_rsp_net_ready) && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (!(arp_req_user_ready && set_ip_user_ready && set_mac_user_ready && arp_rsp_net_ready))
    begin
      $display("%s: input readys did not rise after reset", test_name);
      timeout_count++;
    end

    // Requests back to back, latency checked by the monitor
    test_name = "request_pass";
    for (int i = 0; i < req_count; i++) req_items[i] = rand_word();
    for (int i = 0; i < req_count; i++) send_req(req_items[i]);
    wait_drain(1'b1);

    // Replies under random user back-pressure
    test_name = "back_pressure";
    for (int i = 0; i < rsp_count; i++) begin
      rsp_items[i].hit      = rand_bit();
      rsp_items[i].mac_addr = rand_mac();
      rsp_items[i].ip_addr  = rand_word();
    end
    fork
      begin
        for (int i = 0; i < rsp_count; i++) send_rsp(rsp_items[i]);
        rsp_sent = 1'b1;
      end
      begin
        waited = 0;
        while ((!rsp_sent || rsp_q.size() != 0) && waited < timeout_cycles) begin
          arp_rsp_user_ready = rand_bit();
          @(posedge aclk);
          #1;
          waited++;
        end
        arp_rsp_user_ready = 1'b1;
      end
    join
    assert (rsp_q.size() == 0) else begin
      $display("FAILED %s replies left expected 0 actual %0d", test_name, rsp_q.size());
      mismatch_count++;
    end

    // One stalled channel must not hold up the others
    test_name = "independence";
    for (int i = 0; i < 3; i++) ip_items[i] = rand_word();
    for (int i = 0; i < 4; i++) mac_items[i] = rand_mac();
    for (int i = 0; i < 4; i++) req_items[i] = rand_word();
    set_ip_net_ready = 1'b0;
    fork
      for (int i = 0; i < 3; i++) send_ip(ip_items[i]);
      for (int i = 0; i < 4; i++) send_mac(mac_items[i]);
      for (int i = 0; i < 4; i++) send_req(req_items[i]);
    join
    wait_drain(1'b0);
    // Two slices with skid hold all three IP items
    assert (ip_q.size() == 3 && set_ip_net_valid) else begin
      $display("FAILED %s held ip items expected 3 actual %0d", test_name, ip_q.size());
      mismatch_count++;
    end
    set_ip_net_ready = 1'b1;
    wait_drain(1'b1);

    // Strobe counts against stat_user
    test_name = "statistics";
    for (int i = 0; i < strobe_cycles; i++) begin
      rx_pkt = rand_bit();
      tx_pkt = rand_bit();
      arp_rx = rand_bit();
      arp_tx = rand_bit();
      if (rx_pkt) stat_exp.rx_pkts = stat_exp.rx_pkts + stat_one;
      if (tx_pkt) stat_exp.tx_pkts = stat_exp.tx_pkts + stat_one;
      if (arp_rx) stat_exp.arp_rx = stat_exp.arp_rx + stat_one;
      if (arp_tx) stat_exp.arp_tx = stat_exp.arp_tx + stat_one;
      @(posedge aclk);
      #1;
    end
    rx_pkt = 1'b0;
    tx_pkt = 1'b0;
    arp_rx = 1'b0;
    arp_tx = 1'b0;
    waited = 0;
    while (stat_user != stat_exp && waited < timeout_cycles) begin
      @(posedge aclk);
      #1;
      waited++;
    end
    if (stat_user != stat_exp) begin
      $display("%s: stat_user did not settle on the strobe counts", test_name);
      timeout_count++;
    end
    check_counter("rx_pkts", stat_exp.rx_pkts, stat_user.rx_pkts);
    check_counter("tx_pkts", stat_exp.tx_pkts, stat_user.tx_pkts);
    check_counter("arp_rx", stat_exp.arp_rx, stat_user.arp_rx);
    check_counter("arp_tx", stat_exp.arp_tx, stat_user.arp_tx);

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
